// ==== battle_compositor.sv ====
`timescale 1ns/1ps
// layer priority choice and registered pixel outputs
module battle_compositor (
   input  logic                    clk,
   input  logic                    reset,
   hp_layer_if.sink                user_bar,
   hp_layer_if.sink                enemy_bar,
   input  logic                    team_hit,
   input  battle_pkg::sheet_addr_t team_addr,
   input  logic                    enemy_hit,
   input  battle_pkg::sheet_addr_t enemy_addr,
   output battle_pkg::sheet_addr_t sprite_addr,
   output battle_pkg::layer_t      layer,
   output battle_pkg::rgb_t        pixel_rgb
);
   import battle_pkg::*;

   layer_t      layer_next;
   sheet_addr_t addr_next;
   rgb_t        rgb_next;

   // border pixels are black, everything else takes the tier colour
   function automatic rgb_t bar_pixel(input logic is_border, input rgb_t fill_rgb);
      if (is_border) begin
         return hp_border_rgb;
      end
      return fill_rgb;
   endfunction

   // user bar, enemy bar, team sprite, enemy sprite
   always_comb begin
      layer_next = layer_none;
      addr_next  = '0;
      rgb_next   = '0;
      if (user_bar.is_bar) begin
         layer_next = layer_user_bar;
         rgb_next   = bar_pixel(user_bar.is_border, user_bar.color);
      end else if (enemy_bar.is_bar) begin
         layer_next = layer_enemy_bar;
         rgb_next   = bar_pixel(enemy_bar.is_border, enemy_bar.color);
      end else if (team_hit) begin
         layer_next = layer_team_sprite;
         addr_next  = team_addr; // colour comes from the sheet lookup
      end else if (enemy_hit) begin
         layer_next = layer_enemy_sprite;
         addr_next  = enemy_addr;
      end
   end

   // single output stage
   always_ff @(posedge clk) begin
      if (reset) begin
         layer       <= layer_none;
         sprite_addr <= '0;
         pixel_rgb   <= '0;
      end else begin
         layer       <= layer_next;
         sprite_addr <= addr_next;
         pixel_rgb   <= rgb_next;
      end
   end

endmodule

// ==== battle_overlay.f ====
battle_pkg.sv
hp_layer_if.sv
sprite_window.sv
hp_bar.sv
battle_compositor.sv
battle_overlay.sv
+incdir+.
tb_battle_overlay.sv

// ==== battle_overlay.sv ====
`timescale 1ns/1ps
// battle screen overlay top with two sprite windows, two hp bars and the compositor
module battle_overlay #(
   parameter battle_pkg::coord_t team_x      = 10'd250,
   parameter battle_pkg::coord_t team_y      = 10'd290,
   parameter battle_pkg::coord_t enemy_x     = 10'd410,
   parameter battle_pkg::coord_t enemy_y     = 10'd160,
   parameter battle_pkg::coord_t user_bar_x  = 10'd280, // overlaps the team sprite
   parameter battle_pkg::coord_t user_bar_y  = 10'd300,
   parameter battle_pkg::coord_t enemy_bar_x = 10'd120,
   parameter battle_pkg::coord_t enemy_bar_y = 10'd60
) (
   input  logic                    clk,
   input  logic                    reset,
   input  battle_pkg::coord_t      draw_x,
   input  battle_pkg::coord_t      draw_y,
   input  battle_pkg::poke_id_t    team_id,
   input  battle_pkg::poke_id_t    enemy_id,
   input  battle_pkg::hp_t         user_max_hp,
   input  battle_pkg::hp_t         user_cur_hp,
   input  battle_pkg::hp_t         enemy_max_hp,
   input  battle_pkg::hp_t         enemy_cur_hp,
   output battle_pkg::sheet_addr_t sprite_addr,
   output battle_pkg::layer_t      layer,
   output battle_pkg::rgb_t        pixel_rgb
);
   import battle_pkg::*;

   logic        team_hit;
   sheet_addr_t team_addr;
   logic        enemy_hit;
   sheet_addr_t enemy_addr;

   hp_layer_if user_bar_if ();
   hp_layer_if enemy_bar_if ();

   // player's creature seen from behind
   sprite_window #(
      .origin_x (team_x),
      .origin_y (team_y),
      .facing   (facing_back)
   ) u_team_sprite (
      .draw_x  (draw_x),
      .draw_y  (draw_y),
      .poke_id (team_id),
      .hit     (team_hit),
      .addr    (team_addr)
   );

   sprite_window #(
      .origin_x (enemy_x),
      .origin_y (enemy_y),
      .facing   (facing_front)
   ) u_enemy_sprite (
      .draw_x  (draw_x),
      .draw_y  (draw_y),
      .poke_id (enemy_id),
      .hit     (enemy_hit),
      .addr    (enemy_addr)
   );

   hp_bar #(
      .start_x (user_bar_x),
      .start_y (user_bar_y)
   ) u_user_bar (
      .clk    (clk),
      .reset  (reset),
      .draw_x (draw_x),
      .draw_y (draw_y),
      .max_hp (user_max_hp),
      .cur_hp (user_cur_hp),
      .layer  (user_bar_if.source)
   );

   hp_bar #(
      .start_x (enemy_bar_x),
      .start_y (enemy_bar_y)
   ) u_enemy_bar (
      .clk    (clk),
      .reset  (reset),
      .draw_x (draw_x),
      .draw_y (draw_y),
      .max_hp (enemy_max_hp),
      .cur_hp (enemy_cur_hp),
      .layer  (enemy_bar_if.source)
   );

   battle_compositor u_compositor (
      .clk         (clk),
      .reset       (reset),
      .user_bar    (user_bar_if.sink),
      .enemy_bar   (enemy_bar_if.sink),
      .team_hit    (team_hit),
      .team_addr   (team_addr),
      .enemy_hit   (enemy_hit),
      .enemy_addr  (enemy_addr),
      .sprite_addr (sprite_addr),
      .layer       (layer),
      .pixel_rgb   (pixel_rgb)
   );

endmodule

// ==== battle_pkg.sv ====
// coordinate, colour, address, id and hp types, sheet geometry, bar colours, enums
package battle_pkg;

   // screen and sheet types
   typedef logic [9:0]  coord_t;
   typedef logic [2:0]  poke_id_t;
   typedef logic [7:0]  hp_t;
   typedef logic [18:0] sheet_addr_t;
   typedef logic [7:0]  color_t;

   typedef struct packed {
      color_t r;
      color_t g;
      color_t b;
   } rgb_t;

   // column offset of the sprite within its pair on the sheet
   typedef enum logic {
      facing_back  = 1'b0,
      facing_front = 1'b1
   } facing_t;

   typedef enum logic [1:0] {
      tier_green  = 2'd0,
      tier_yellow = 2'd1,
      tier_red    = 2'd2
   } hp_tier_t;

   typedef enum logic [2:0] {
      layer_none         = 3'd0,
      layer_user_bar     = 3'd1,
      layer_enemy_bar    = 3'd2,
      layer_team_sprite  = 3'd3,
      layer_enemy_sprite = 3'd4
   } layer_t;

   // sprite sheet is 4 sprites wide, 4 rows of creature pairs
   localparam int sprite_size = 56;
   localparam int sheet_width = 224;

   // bar interior, border sits one pixel outside
   localparam int bar_width  = 50;
   localparam int bar_height = 5;

   localparam rgb_t hp_green_rgb  = 24'h41ff74;
   localparam rgb_t hp_yellow_rgb = 24'hffae42; // orange-ish yellow
   localparam rgb_t hp_red_rgb    = 24'hff3300;
   localparam rgb_t hp_border_rgb = 24'h000000;

endpackage

// ==== hp_bar.sv ====
`timescale 1ns/1ps
// hp bar fill width register, border and fill hit test, colour tier
module hp_bar #(
   parameter battle_pkg::coord_t start_x = 10'd280,
   parameter battle_pkg::coord_t start_y = 10'd300
) (
   input  logic               clk,
   input  logic               reset,
   input  battle_pkg::coord_t draw_x,
   input  battle_pkg::coord_t draw_y,
   input  battle_pkg::hp_t    max_hp,
   input  battle_pkg::hp_t    cur_hp,
   hp_layer_if.source         layer
);
   import battle_pkg::*;

   localparam int fill_w = $clog2(bar_width + 1);

   // border rectangle corners, 52 x 7 around the interior
   localparam int left_x   = int'(start_x) - 1;
   localparam int right_x  = int'(start_x) + bar_width;
   localparam int top_y    = int'(start_y) - 1;
   localparam int bottom_y = int'(start_y) + bar_height;

   logic [fill_w-1:0] fill_next;
   logic [fill_w-1:0] fill_q;
   logic              in_x_span;
   logic              in_y_span;
   logic              on_border;
   logic              in_fill;

   always_comb begin
      if (max_hp == cur_hp) begin
         fill_next = fill_w'(bar_width);
      end else if (max_hp == '0) begin
         fill_next = '0; // nothing to scale against
      end else begin
         fill_next = fill_w'((bar_width * cur_hp / max_hp) % bar_width);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         fill_q <= '0;
      end else begin
         fill_q <= fill_next;
      end
   end

   assign in_x_span = (draw_x >= left_x) && (draw_x <= right_x);
   assign in_y_span = (draw_y >= top_y) && (draw_y <= bottom_y);

   // top and bottom rows, then left and right columns
   assign on_border = (in_x_span && (draw_y == top_y || draw_y == bottom_y))
                      || (in_y_span && (draw_x == left_x || draw_x == right_x));

   assign in_fill = (draw_x >= start_x)
                    && (int'(draw_x) < int'(start_x) + int'(fill_q))
                    && (draw_y >= start_y)
                    && (int'(draw_y) < int'(start_y) + bar_height);

   assign layer.is_border = on_border;
   assign layer.is_bar    = on_border || in_fill; // border wins over fill downstream

   always_comb begin
      if (2 * fill_q > bar_width) begin
         layer.tier = tier_green;  // above half
      end else if (5 * fill_q > bar_width) begin
         layer.tier = tier_yellow; // above a fifth
      end else begin
         layer.tier = tier_red;
      end
   end

   always_comb begin
      case (layer.tier)
         tier_green:  layer.color = hp_green_rgb;
         tier_yellow: layer.color = hp_yellow_rgb;
         default:     layer.color = hp_red_rgb;
      endcase
   end

endmodule

// ==== hp_layer_if.sv ====
`timescale 1ns/1ps
// interface for one hp bar's pixel result toward the compositor
interface hp_layer_if;
   import battle_pkg::*;

   logic     is_bar;    // border or fill covers the pixel
   hp_tier_t tier;
   logic     is_border;
   rgb_t     color;     // fill colour of the current tier

   modport source (
      output is_bar,
      output tier,
      output is_border,
      output color
   );

   modport sink (
      input is_bar,
      input tier,
      input is_border,
      input color
   );

endinterface

// ==== sprite_window.sv ====
`timescale 1ns/1ps
// creature sprite window hit test and sprite sheet address
module sprite_window #(
   parameter battle_pkg::coord_t  origin_x = 10'd250,
   parameter battle_pkg::coord_t  origin_y = 10'd290,
   parameter battle_pkg::facing_t facing   = battle_pkg::facing_back
) (
   input  battle_pkg::coord_t      draw_x,
   input  battle_pkg::coord_t      draw_y,
   input  battle_pkg::poke_id_t    poke_id,
   output logic                    hit,
   output battle_pkg::sheet_addr_t addr
);
   import battle_pkg::*;

   coord_t     dx;
   coord_t     dy;
   logic [1:0] sheet_row;
   logic [1:0] sheet_col;
   logic       in_x;
   logic       in_y;

   // offset inside the window, only meaningful on a hit
   assign dx = draw_x - origin_x;
   assign dy = draw_y - origin_y;

   // two creatures per sheet row, each with a back and a front column
   assign sheet_row = poke_id[2:1];
   assign sheet_col = {poke_id[0], logic'(facing)};

   assign in_x = (draw_x >= origin_x) && (draw_x < origin_x + sprite_size);
   assign in_y = (draw_y >= origin_y) && (draw_y < origin_y + sprite_size);

   always_comb begin
      hit = in_x && in_y;
      if (hit) begin
         addr = sheet_addr_t'(dy * sheet_width
                              + dx
                              + sheet_col * sprite_size
                              + sheet_row * sheet_width * sprite_size);
      end else begin
         addr = '0;
      end
   end

endmodule

// ==== tb_battle_ref.svh ====
// reference model for sprite window, sheet address, fill width, bar cover and expected pixel

function automatic bit in_sprite(input int x, input int y, input int ox, input int oy);
   return (x >= ox) && (x <= ox + sprite_size - 1) && (y >= oy) && (y <= oy + sprite_size - 1);
endfunction

// sheet holds creature pairs per row, back then front for each
function automatic int sprite_addr_ref(input int x, input int y, input int ox, input int oy,
                                       input int id, input int face);
   int row;
   int col;
   row = id / 2;
   col = (id % 2) * 2 + face;
   return (y - oy) * sheet_width + (x - ox) + col * sprite_size
          + row * sheet_width * sprite_size;
endfunction

function automatic int fill_ref(input int max_hp, input int cur_hp);
   if (max_hp == cur_hp) begin
      return bar_width;
   end
   if (max_hp == 0) begin
      return 0;
   end
   return (bar_width * cur_hp / max_hp) % bar_width;
endfunction

// 0 nothing, 1 border, 2 fill
function automatic int bar_cover(input int x, input int y, input int sx, input int sy,
                                 input int fill);
   if (x < sx - 1 || x > sx + bar_width || y < sy - 1 || y > sy + bar_height) begin
      return 0;
   end
   if (x == sx - 1 || x == sx + bar_width || y == sy - 1 || y == sy + bar_height) begin
      return 1;
   end
   return (x < sx + fill) ? 2 : 0;
endfunction

function automatic rgb_t tier_rgb(input int fill);
   if (fill * 2 > bar_width) begin
      return hp_green_rgb;
   end else if (fill * 5 > bar_width) begin
      return hp_yellow_rgb;
   end
   return hp_red_rgb;
endfunction

function automatic void pixel_ref(input bit in_reset, input int x, input int y,
                                  input int tid, input int eid,
                                  input int fill_u, input int fill_e,
                                  output layer_t l, output sheet_addr_t a, output rgb_t c);
   int cover_u;
   int cover_e;
   l = layer_none;
   a = '0;
   c = '0;
   cover_u = bar_cover(x, y, user_bar_x, user_bar_y, fill_u);
   cover_e = bar_cover(x, y, enemy_bar_x, enemy_bar_y, fill_e);
   if (in_reset) begin
      l = layer_none; // outputs held clear
   end else if (cover_u != 0) begin
      l = layer_user_bar;
      c = (cover_u == 1) ? hp_border_rgb : tier_rgb(fill_u);
   end else if (cover_e != 0) begin
      l = layer_enemy_bar;
      c = (cover_e == 1) ? hp_border_rgb : tier_rgb(fill_e);
   end else if (in_sprite(x, y, team_x, team_y)) begin
      l = layer_team_sprite;
      a = sheet_addr_t'(sprite_addr_ref(x, y, team_x, team_y, tid, 0));
   end else if (in_sprite(x, y, enemy_x, enemy_y)) begin
      l = layer_enemy_sprite;
      a = sheet_addr_t'(sprite_addr_ref(x, y, enemy_x, enemy_y, eid, 1));
   end
endfunction

// ==== tb_battle_overlay.sv ====
`timescale 1ns/1ps
// testbench for the battle overlay with reference checks, timeout and report
module tb_battle_overlay;
   import battle_pkg::*;

   localparam int team_x      = 250;
   localparam int team_y      = 290;
   localparam int enemy_x     = 410;
   localparam int enemy_y     = 160;
   localparam int user_bar_x  = 280;
   localparam int user_bar_y  = 300;
   localparam int enemy_bar_x = 120;
   localparam int enemy_bar_y = 60;

   localparam int reset_cycles = 16;
   localparam int num_hp_pairs = 8;
   localparam int num_random   = 400;
   // cycles per test rounded up
   localparam int len_idle    = 8;
   localparam int len_windows = 2 * 8 * 9 + 2;
   localparam int len_borders = 2 * (2 * (bar_width + 2) + 2 * (bar_height + 2)) + 2;
   localparam int len_fill    = num_hp_pairs * (5 + 2 * bar_width) + 2;
   localparam int len_overlap = 12;
   localparam int len_random  = num_random + (num_random / 50) * 5 + 2;
   localparam int timeout_cycles = 2 * (len_idle + len_windows + len_borders + len_fill
                                        + len_overlap + len_random) + reset_cycles;

   `include "tb_battle_ref.svh"

   logic        clk;
   logic        reset;
   coord_t      draw_x;
   coord_t      draw_y;
   poke_id_t    team_id;
   poke_id_t    enemy_id;
   hp_t         user_max_hp;
   hp_t         user_cur_hp;
   hp_t         enemy_max_hp;
   hp_t         enemy_cur_hp;
   sheet_addr_t sprite_addr;
   layer_t      layer;
   rgb_t        pixel_rgb;

   // what the dut saw at the last rising edge
   logic        hist_valid;
   logic        hist_reset;
   int          hist_x;
   int          hist_y;
   int          hist_team_id;
   int          hist_enemy_id;
   int          hist_fill_user;
   int          hist_fill_enemy;
   int          fill_user_m;  // model of the fill registers
   int          fill_enemy_m;

   layer_t      exp_layer;
   sheet_addr_t exp_addr;
   rgb_t        exp_rgb;
   int          seed;
   int          check_count;
   int          err_count;
   int          test_checks;
   int          test_errs;
   int          cycle_count;
   int          hp_max_list [num_hp_pairs] = '{100, 100, 100, 100, 100, 100, 0, 0};
   int          hp_cur_list [num_hp_pairs] = '{100, 50, 22, 21, 10, 0, 5, 0};

   battle_overlay #(
      .team_x (team_x), .team_y (team_y), .enemy_x (enemy_x), .enemy_y (enemy_y),
      .user_bar_x (user_bar_x), .user_bar_y (user_bar_y),
      .enemy_bar_x (enemy_bar_x), .enemy_bar_y (enemy_bar_y)
   ) battle_overlay_i (
      .clk (clk), .reset (reset), .draw_x (draw_x), .draw_y (draw_y),
      .team_id (team_id), .enemy_id (enemy_id),
      .user_max_hp (user_max_hp), .user_cur_hp (user_cur_hp),
      .enemy_max_hp (enemy_max_hp), .enemy_cur_hp (enemy_cur_hp),
      .sprite_addr (sprite_addr), .layer (layer), .pixel_rgb (pixel_rgb)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      hist_valid      <= 1'b1;
      hist_reset      <= reset;
      hist_x          <= draw_x;
      hist_y          <= draw_y;
      hist_team_id    <= team_id;
      hist_enemy_id   <= enemy_id;
      hist_fill_user  <= fill_user_m;
      hist_fill_enemy <= fill_enemy_m;
      fill_user_m     <= reset ? 0 : fill_ref(user_max_hp, user_cur_hp);
      fill_enemy_m    <= reset ? 0 : fill_ref(enemy_max_hp, enemy_cur_hp);
   end

   // compare against the inputs of the previous rising edge
   always @(negedge clk) begin
      if (hist_valid) begin
         pixel_ref(hist_reset, hist_x, hist_y, hist_team_id, hist_enemy_id,
                   hist_fill_user, hist_fill_enemy, exp_layer, exp_addr, exp_rgb);
         check_count++;
         assert (layer === exp_layer) else begin
            $display("error: layer got %h expected %h (x %0d y %0d)",
                     layer, exp_layer, hist_x, hist_y);
            err_count++;
         end
         assert (sprite_addr === exp_addr) else begin
            $display("error: sprite_addr got %h expected %h (x %0d y %0d)",
                     sprite_addr, exp_addr, hist_x, hist_y);
            err_count++;
         end
         assert (pixel_rgb === exp_rgb) else begin
            $display("error: pixel_rgb got %h expected %h (x %0d y %0d)",
                     pixel_rgb, exp_rgb, hist_x, hist_y);
            err_count++;
         end
      end
   end

   task automatic drive_pixel(input int x, input int y);
      @(negedge clk);
      draw_x = coord_t'(x);
      draw_y = coord_t'(y);
   endtask

   // coordinate held on a user bar fill pixel across the hp change
   task automatic change_hp(input int um, input int uc, input int em, input int ec);
      repeat (2) drive_pixel(user_bar_x + 4, user_bar_y + 2);
      user_max_hp  = hp_t'(um);
      user_cur_hp  = hp_t'(uc);
      enemy_max_hp = hp_t'(em);
      enemy_cur_hp = hp_t'(ec);
      repeat (2) drive_pixel(user_bar_x + 4, user_bar_y + 2);
   endtask

   task automatic report_test(input string name);
      @(negedge clk);
      #1;
      $display("%s: %0d pixels checked, %0d errors", name,
               check_count - test_checks, err_count - test_errs);
      test_checks = check_count;
      test_errs   = err_count;
   endtask

   task automatic scan_window(input int ox, input int oy);
      int id;
      for (id = 0; id < 8; id++) begin
         drive_pixel(ox, oy);
         team_id  = poke_id_t'(id);
         enemy_id = poke_id_t'(7 - id);
         drive_pixel(ox + sprite_size - 1, oy);
         drive_pixel(ox, oy + sprite_size - 1);
         drive_pixel(ox + sprite_size - 1, oy + sprite_size - 1);
         drive_pixel(ox + sprite_size / 2, oy + sprite_size / 2);
         drive_pixel(ox - 1, oy);  // just outside each side
         drive_pixel(ox + sprite_size, oy + sprite_size - 1);
         drive_pixel(ox, oy - 1);
         drive_pixel(ox + sprite_size - 1, oy + sprite_size);
      end
   endtask

   task automatic scan_border(input int sx, input int sy);
      int i;
      for (i = sx - 1; i <= sx + bar_width; i++) begin
         drive_pixel(i, sy - 1);
         drive_pixel(i, sy + bar_height);
      end
      for (i = sy - 1; i <= sy + bar_height; i++) begin
         drive_pixel(sx - 1, i);
         drive_pixel(sx + bar_width, i);
      end
   endtask

   task automatic scan_fill();
      int p;
      int i;
      for (p = 0; p < num_hp_pairs; p++) begin
         change_hp(hp_max_list[p], hp_cur_list[p],
                   hp_max_list[num_hp_pairs - 1 - p], hp_cur_list[num_hp_pairs - 1 - p]);
         for (i = 0; i < bar_width; i++) begin
            drive_pixel(user_bar_x + i, user_bar_y + 2);
         end
         for (i = 0; i < bar_width; i++) begin
            drive_pixel(enemy_bar_x + i, enemy_bar_y + 2);
         end
      end
   endtask

   task automatic run_random();
      int i;
      int r;
      int m;
      int bx [4] = '{team_x, enemy_x, user_bar_x, enemy_bar_x};
      int by [4] = '{team_y, enemy_y, user_bar_y, enemy_bar_y};
      for (i = 0; i < num_random; i++) begin
         if (i % 50 == 0) begin
            m = $unsigned($random(seed)) % 256;
            change_hp(m, $unsigned($random(seed)) % (m + 1),
                      $unsigned($random(seed)) % 256, $unsigned($random(seed)) % 256);
         end
         if (i % 2 == 0) begin
            drive_pixel($unsigned($random(seed)) % 640, $unsigned($random(seed)) % 480);
         end else begin
            r = $unsigned($random(seed)) % 4; // aim near one region
            drive_pixel(bx[r] - 10 + $unsigned($random(seed)) % 76,
                        by[r] - 10 + $unsigned($random(seed)) % ((r >= 2) ? 18 : 76));
         end
         team_id  = poke_id_t'($random(seed));
         enemy_id = poke_id_t'($random(seed));
      end
   endtask

   initial begin
      cycle_count = 0;
      while (cycle_count < timeout_cycles) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("Test failed");
      $finish;
   end

   initial begin
      clk          = 1'b0;
      reset        = 1'b1;
      draw_x       = '0;
      draw_y       = '0;
      team_id      = '0;
      enemy_id     = '0;
      user_max_hp  = 8'd100;
      user_cur_hp  = 8'd100;
      enemy_max_hp = 8'd100;
      enemy_cur_hp = 8'd100;
      hist_valid   = 1'b0;
      fill_user_m  = 0;
      fill_enemy_m = 0;
      seed         = 32'h2d4b;
      check_count  = 0;
      err_count    = 0;
      test_checks  = 0;
      test_errs    = 0;
      repeat (reset_cycles) @(negedge clk);
      reset = 1'b0;
      repeat (4) drive_pixel(0, 0);
      report_test("reset and idle");
      scan_window(team_x, team_y);
      scan_window(enemy_x, enemy_y);
      report_test("sprite windows");
      scan_border(user_bar_x, user_bar_y);
      scan_border(enemy_bar_x, enemy_bar_y);
      report_test("bar borders");
      scan_fill();
      report_test("fill width and tier");
      change_hp(100, 100, 100, 100);
      team_id = 3'd5;
      drive_pixel(290, 302);  // bar over sprite
      drive_pixel(279, 302);
      drive_pixel(278, 302);  // sprite pixel left of the border
      drive_pixel(290, 298);
      drive_pixel(300, 306);
      report_test("bar over sprite");
      run_random();
      report_test("random pixels");
      $display("total: %0d pixels checked, %0d errors", check_count, err_count);
      if (err_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
